//--- verilog.f
+incdir+verif
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_fetch.sv
design/rv_reg_file.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_wb.sv
design/rv_hazard_unit.sv
design/rv_core.sv
verif/tb_rv_core.sv

//--- verif/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// results land at 0x100 and up and wrong-path stores would hit 0x1f0 and up

localparam int          STORE_CNT = 12;
localparam int          OP_IMM    = 'h13;
localparam int          OP_LOAD   = 'h03;
localparam logic [31:0] NOP_WORD  = 32'h0000_0013;     // addi x0, x0, 0

// RV32I instruction formats
function automatic logic [31:0] r_fmt(input int f7, input int rs2, input int rs1,
                                      input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] i_fmt(input int imm, input int rs1, input int f3,
                                      input int rd, input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] s_fmt(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};    // sw only
endfunction

function automatic logic [31:0] b_fmt(input int off, input int rs2, input int rs1,
                                      input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] u_fmt(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], 7'h37};                               // lui
endfunction

// instruction word at each index with nops past the end
function automatic logic [31:0] program_word(input int idx);
    case (idx)
        0:  return i_fmt(12, 0, 0, 1, OP_IMM);          // addi x1, x0, 12
        1:  return i_fmt(10, 0, 0, 2, OP_IMM);          // addi x2, x0, 10
        2:  return r_fmt(0, 2, 1, 0, 3);                // add  x3, x1, x2
        3:  return r_fmt('h20, 2, 3, 0, 4);             // sub  x4, x3, x2
        4:  return s_fmt('h100, 3, 0);                  // sw   x3, 0x100(x0)
        5:  return r_fmt(0, 2, 3, 7, 5);                // and  x5, x3, x2
        6:  return r_fmt(0, 1, 5, 6, 6);                // or   x6, x5, x1
        7:  return s_fmt('h104, 4, 0);                  // sw   x4, 0x104(x0)
        8:  return s_fmt('h108, 5, 0);                  // sw   x5, 0x108(x0)
        9:  return s_fmt('h10c, 6, 0);                  // sw   x6, 0x10c(x0)
        10: return u_fmt('h12345, 7);                   // lui  x7, 0x12345
        11: return i_fmt(-1, 7, 0, 7, OP_IMM);          // addi x7, x7, -1
        12: return s_fmt('h110, 7, 0);                  // sw   x7, 0x110(x0)
        13: return i_fmt(7, 0, 0, 0, OP_IMM);           // addi x0, x0, 7
        14: return r_fmt(0, 1, 0, 0, 8);                // add  x8, x0, x1
        15: return s_fmt('h114, 0, 0);                  // sw   x0, 0x114(x0)
        16: return s_fmt('h118, 8, 0);                  // sw   x8, 0x118(x0)
        17: return i_fmt('h104, 0, 2, 9, OP_LOAD);      // lw   x9, 0x104(x0)
        18: return r_fmt(0, 1, 9, 0, 10);               // add  x10, x9, x1
        19: return s_fmt('h11c, 10, 0);                 // sw   x10, 0x11c(x0)
        20: return b_fmt(8, 4, 1, 0);                   // beq  x1, x4, +8 taken
        21: return s_fmt('h1f0, 2, 0);                  // skipped
        22: return b_fmt(8, 4, 1, 1);                   // bne  x1, x4, +8 not taken
        23: return s_fmt('h120, 2, 0);                  // sw   x2, 0x120(x0)
        24: return i_fmt(-2, 1, 0, 12, OP_IMM);         // addi x12, x1, -2
        25: return b_fmt(8, 2, 12, 0);                  // beq  x12, x2, +8 taken
        26: return s_fmt('h1f4, 1, 0);                  // skipped
        27: return i_fmt('h100, 0, 2, 13, OP_LOAD);     // lw   x13, 0x100(x0)
        28: return b_fmt(8, 3, 13, 1);                  // bne  x13, x3, +8 not taken
        29: return s_fmt('h124, 13, 0);                 // sw   x13, 0x124(x0)
        30: return b_fmt(8, 2, 1, 1);                   // bne  x1, x2, +8 taken
        31: return s_fmt('h1f8, 1, 0);                  // skipped
        32: return b_fmt(8, 2, 1, 0);                   // beq  x1, x2, +8 not taken
        33: return s_fmt('h128, 1, 0);                  // sw   x1, 0x128(x0)
        34: return i_fmt('h110, 0, 2, 11, OP_LOAD);     // lw   x11, 0x110(x0)
        35: return s_fmt('h12c, 11, 0);                 // sw   x11, 0x12c(x0)
        default: return NOP_WORD;
    endcase
endfunction

// {address, data} of each store in program order
function automatic logic [63:0] expected_store(input int idx);
    case (idx)
        0:  return {32'h0000_0100, 32'h0000_0016};      // 12 + 10
        1:  return {32'h0000_0104, 32'h0000_000c};      // 22 - 10
        2:  return {32'h0000_0108, 32'h0000_0002};      // 0x16 & 0x0a
        3:  return {32'h0000_010c, 32'h0000_000e};      // 0x02 | 0x0c
        4:  return {32'h0000_0110, 32'h1234_4fff};
        5:  return {32'h0000_0114, 32'h0000_0000};      // x0
        6:  return {32'h0000_0118, 32'h0000_000c};
        7:  return {32'h0000_011c, 32'h0000_0018};      // loaded 12 + 12
        8:  return {32'h0000_0120, 32'h0000_000a};
        9:  return {32'h0000_0124, 32'h0000_0016};
        10: return {32'h0000_0128, 32'h0000_000c};
        default: return {32'h0000_012c, 32'h1234_4fff};
    endcase
endfunction

`endif

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int STORE_TIMEOUT = 200;     // cycles allowed per store
    localparam int DRAIN_CYCLES  = 40;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr_rdata;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_we;
    logic        data_req;
    logic        data_ack;
    logic [31:0] data_rdata;

    logic [31:0] rom_addr_q;                // address seen at the last rising edge
    logic [31:0] dmem [0:255];              // 1 KiB data memory
    logic [63:0] store_log [$];             // acknowledged stores as {addr, data}
    logic        busy;
    int          delay;
    integer      seed = 32'hafa8_2acf;
    logic [63:0] got_store;
    logic [63:0] exp_store;
    int          idx;
    int          i;

    `include "tb_program.svh"

    rv_core #(.RESET_PC(32'h0000_0000)) rv_core_inst
    (
        .clk(clk), .arst_n_i(arst_n),
        .instr_addr_o(instr_addr), .instr_rdata_i(instr_rdata),
        .data_addr_o(data_addr), .data_wdata_o(data_wdata), .data_we_o(data_we),
        .data_req_o(data_req), .data_ack_i(data_ack), .data_rdata_i(data_rdata)
    );

    always #10 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
                                      name, got, exp));
    endtask

    task automatic wait_for_store(input int num);
        int cycles;
        cycles = 0;
        while (store_log.size() == 0 && cycles < STORE_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (store_log.size() == 0)
            stop_with_error($sformatf("store %0d did not arrive within %0d cycles",
                                      num, STORE_TIMEOUT));
    endtask

    task automatic serve_access();
        if (data_addr[31:10] != '0 || data_addr[1:0] != 2'b00)
            stop_with_error($sformatf("data access to 0x%08h is outside the memory",
                                      data_addr));
        else if (data_we)
        begin
            dmem[data_addr[9:2]] = data_wdata;
            store_log.push_back({data_addr, data_wdata});
        end
        else
            data_rdata <= dmem[data_addr[9:2]];
    endtask

    // sync ROM whose word shows up half a cycle after the edge
    always @(posedge clk)
        rom_addr_q <= instr_addr;

    always @(negedge clk)
        instr_rdata <= program_word(rom_addr_q[31:2]);

    // data memory with a random wait before each ack
    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            data_ack <= 1'b0;
            busy = 1'b0;
        end
        else
        begin
            data_ack <= 1'b0;
            if (data_req)
            begin
                if (!busy)
                begin
                    busy  = 1'b1;                   // new request
                    delay = $random(seed) & 3;
                end
                if (delay == 0)
                begin
                    serve_access();
                    data_ack <= 1'b1;
                    busy = 1'b0;
                end
                else
                    delay = delay - 1;
            end
        end
    end

    initial
    begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_rdata = NOP_WORD;
        data_ack    = 1'b0;
        data_rdata  = '0;
        rom_addr_q  = '0;
        busy        = 1'b0;
        delay       = 0;
        for (i = 0; i < 256; i++)
            dmem[i] = 32'h5e5e_0000 ^ (i * 4);     // pattern from the byte address
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1;

        for (idx = 0; idx < STORE_CNT; idx++)
        begin
            wait_for_store(idx);
            got_store = store_log.pop_front();
            exp_store = expected_store(idx);
            check_value("data_addr_o", got_store[63:32], exp_store[63:32]);
            check_value("data_wdata_o", got_store[31:0], exp_store[31:0]);
        end

        repeat (DRAIN_CYCLES) @(posedge clk);      // program tail runs nops only
        if (store_log.size() != 0)
            stop_with_error("a store appeared after the last expected one");
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
#(
    parameter rv_pipe_pkg::word_t RESET_PC = 32'h0000_0000
)(
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    // instruction ROM
    output rv_pipe_pkg::word_t      instr_addr_o,
    input  wire rv_isa_pkg::instr_t instr_rdata_i,
    // data port
    output rv_pipe_pkg::word_t      data_addr_o,
    output rv_pipe_pkg::word_t      data_wdata_o,
    output logic                    data_we_o,
    output logic                    data_req_o,
    input  wire logic               data_ack_i,
    input  wire rv_pipe_pkg::word_t data_rdata_i
);

    rv_isa_pkg::instr_t    f_instr;
    rv_pipe_pkg::word_t    f_pc, branch_target;
    logic                  branch_taken, d_branch;
    rv_isa_pkg::reg_addr_t d_ra1, d_ra2;
    rv_pipe_pkg::word_t    ex_rd1, ex_rd2, ex_imm;
    rv_isa_pkg::alu_op_e   ex_alu_op;
    rv_isa_pkg::reg_addr_t ex_rd, ex_ra1, ex_ra2;
    logic                  ex_src_imm, ex_we, ex_load, ex_store;
    rv_pipe_pkg::word_t    mem_result, mem_wdata, mem_fwd;
    rv_isa_pkg::reg_addr_t mem_rd, wb_rd;
    logic                  mem_we, mem_load, mem_store, wb_we;
    rv_pipe_pkg::word_t    wb_result;
    rv_pipe_pkg::bypass_e  rd1_bp, rd2_bp;
    logic                  cmp1_bp, cmp2_bp, stall_front, flush_ex, freeze;

    rv_fetch #(.RESET_PC(RESET_PC)) rv_fetch_inst
    (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall_front), .freeze_i(freeze),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .instr_addr_o(instr_addr_o), .instr_rdata_i(instr_rdata_i),
        .instr_o(f_instr), .pc_o(f_pc)
    );

    rv_decode rv_decode_inst
    (
        .clk(clk), .arst_n_i(arst_n_i), .instr_i(f_instr), .pc_i(f_pc),
        .cmp1_bp_i(cmp1_bp), .cmp2_bp_i(cmp2_bp), .mem_result_i(mem_fwd),
        .wb_rd_i(wb_rd), .wb_result_i(wb_result), .wb_we_i(wb_we),
        .flush_i(flush_ex), .stall_i(stall_front), .freeze_i(freeze),
        .ra1_o(d_ra1), .ra2_o(d_ra2), .branch_o(d_branch),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .ex_rd1_o(ex_rd1), .ex_rd2_o(ex_rd2), .ex_imm_o(ex_imm),
        .ex_alu_op_o(ex_alu_op), .ex_src_imm_o(ex_src_imm),
        .ex_rd_o(ex_rd), .ex_ra1_o(ex_ra1), .ex_ra2_o(ex_ra2),
        .ex_we_o(ex_we), .ex_load_o(ex_load), .ex_store_o(ex_store)
    );

    rv_execute rv_execute_inst
    (
        .clk(clk), .arst_n_i(arst_n_i), .freeze_i(freeze),
        .ex_rd1_i(ex_rd1), .ex_rd2_i(ex_rd2), .ex_imm_i(ex_imm),
        .ex_alu_op_i(ex_alu_op), .ex_src_imm_i(ex_src_imm), .ex_rd_i(ex_rd),
        .ex_we_i(ex_we), .ex_load_i(ex_load), .ex_store_i(ex_store),
        .rd1_bp_i(rd1_bp), .rd2_bp_i(rd2_bp),
        .mem_result_i(mem_fwd), .wb_result_i(wb_result),
        .mem_result_o(mem_result), .mem_wdata_o(mem_wdata), .mem_rd_o(mem_rd),
        .mem_we_o(mem_we), .mem_load_o(mem_load), .mem_store_o(mem_store)
    );

    rv_mem_wb rv_mem_wb_inst
    (
        .clk(clk), .arst_n_i(arst_n_i), .freeze_i(freeze),
        .mem_result_i(mem_result), .mem_wdata_i(mem_wdata), .mem_rd_i(mem_rd),
        .mem_we_i(mem_we), .mem_load_i(mem_load), .mem_store_i(mem_store),
        .data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o), .data_we_o(data_we_o),
        .data_req_o(data_req_o), .data_ack_i(data_ack_i), .data_rdata_i(data_rdata_i),
        .wb_result_o(wb_result), .wb_rd_o(wb_rd), .wb_we_o(wb_we),
        .mem_result_o(mem_fwd)
    );

    rv_hazard_unit rv_hazard_unit_inst
    (
        .d_ra1_i(d_ra1), .d_ra2_i(d_ra2), .d_branch_i(d_branch),
        .ex_ra1_i(ex_ra1), .ex_ra2_i(ex_ra2), .ex_rd_i(ex_rd),
        .ex_we_i(ex_we), .ex_load_i(ex_load),
        .mem_rd_i(mem_rd), .mem_we_i(mem_we), .mem_load_i(mem_load),
        .wb_rd_i(wb_rd), .wb_we_i(wb_we),
        .data_req_i(data_req_o), .data_ack_i(data_ack_i),
        .rd1_bp_o(rd1_bp), .rd2_bp_o(rd2_bp), .cmp1_bp_o(cmp1_bp), .cmp2_bp_o(cmp2_bp),
        .stall_front_o(stall_front), .flush_ex_o(flush_ex), .freeze_o(freeze)
    );

endmodule

`default_nettype wire

//--- design/rv_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit
(
    input  wire rv_isa_pkg::reg_addr_t d_ra1_i,
    input  wire rv_isa_pkg::reg_addr_t d_ra2_i,
    input  wire logic                  d_branch_i,
    input  wire rv_isa_pkg::reg_addr_t ex_ra1_i,
    input  wire rv_isa_pkg::reg_addr_t ex_ra2_i,
    input  wire rv_isa_pkg::reg_addr_t ex_rd_i,
    input  wire logic                  ex_we_i,
    input  wire logic                  ex_load_i,
    input  wire rv_isa_pkg::reg_addr_t mem_rd_i,
    input  wire logic                  mem_we_i,
    input  wire logic                  mem_load_i,
    input  wire rv_isa_pkg::reg_addr_t wb_rd_i,
    input  wire logic                  wb_we_i,
    input  wire logic                  data_req_i,
    input  wire logic                  data_ack_i,
    output rv_pipe_pkg::bypass_e       rd1_bp_o,
    output rv_pipe_pkg::bypass_e       rd2_bp_o,
    output logic                       cmp1_bp_o,
    output logic                       cmp2_bp_o,
    output logic                       stall_front_o,
    output logic                       flush_ex_o,
    output logic                       freeze_o
);

    logic load_use, branch_wait, ex_dep, mem_dep;

    function automatic logic match(input rv_isa_pkg::reg_addr_t rd,
                                   input rv_isa_pkg::reg_addr_t ra);
        return (rd != '0) && (rd == ra);    // x0 never forwards
    endfunction

    function automatic rv_pipe_pkg::bypass_e fwd_sel(input rv_isa_pkg::reg_addr_t ra);
        if (mem_we_i && match(mem_rd_i, ra))
            return rv_pipe_pkg::BP_MEM;     // newest value wins
        else if (wb_we_i && match(wb_rd_i, ra))
            return rv_pipe_pkg::BP_WB;
        else
            return rv_pipe_pkg::BP_NONE;
    endfunction

    always_comb
    begin
        rd1_bp_o = fwd_sel(ex_ra1_i);
        rd2_bp_o = fwd_sel(ex_ra2_i);
    end

    // load data is not there yet in memory, so those cases stall instead
    assign cmp1_bp_o = mem_we_i && !mem_load_i && match(mem_rd_i, d_ra1_i);
    assign cmp2_bp_o = mem_we_i && !mem_load_i && match(mem_rd_i, d_ra2_i);

    assign ex_dep  = match(ex_rd_i, d_ra1_i) || match(ex_rd_i, d_ra2_i);
    assign mem_dep = match(mem_rd_i, d_ra1_i) || match(mem_rd_i, d_ra2_i);

    assign load_use    = ex_load_i && ex_dep;
    assign branch_wait = d_branch_i && ((ex_we_i && ex_dep) || (mem_load_i && mem_dep));

    assign stall_front_o = load_use || branch_wait;
    assign flush_ex_o    = stall_front_o;               // bubble behind the held decode
    assign freeze_o      = data_req_i && !data_ack_i;

endmodule

`default_nettype wire

//--- design/rv_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mem_wb
(
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    input  wire logic                  freeze_i,
    input  wire rv_pipe_pkg::word_t    mem_result_i,
    input  wire rv_pipe_pkg::word_t    mem_wdata_i,
    input  wire rv_isa_pkg::reg_addr_t mem_rd_i,
    input  wire logic                  mem_we_i,
    input  wire logic                  mem_load_i,
    input  wire logic                  mem_store_i,
    output rv_pipe_pkg::word_t         data_addr_o,
    output rv_pipe_pkg::word_t         data_wdata_o,
    output logic                       data_we_o,
    output logic                       data_req_o,
    input  wire logic                  data_ack_i,
    input  wire rv_pipe_pkg::word_t    data_rdata_i,
    output rv_pipe_pkg::word_t         wb_result_o,
    output rv_isa_pkg::reg_addr_t      wb_rd_o,
    output logic                       wb_we_o,
    output rv_pipe_pkg::word_t         mem_result_o
);

    // the memory-stage register stays put under freeze, so the request holds
    assign data_addr_o  = mem_result_i;
    assign data_wdata_o = mem_wdata_i;
    assign data_we_o    = mem_store_i;
    assign data_req_o   = mem_load_i || mem_store_i;
    assign mem_result_o = mem_result_i;     // bypass value for execute and decode

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wb_result_o <= '0;
            wb_rd_o     <= '0;
            wb_we_o     <= 1'b0;
        end
        else if (!freeze_i)
        begin
            // unfrozen load means the ack is here
            wb_result_o <= mem_load_i ? data_rdata_i : mem_result_i;
            wb_rd_o     <= mem_rd_i;
            wb_we_o     <= mem_we_i;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (data_req_o && !data_ack_i) |=>
            (data_req_o && $stable(data_addr_o) && $stable(data_we_o)));

endmodule

`default_nettype wire

//--- design/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute
(
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    input  wire logic                  freeze_i,
    input  wire rv_pipe_pkg::word_t    ex_rd1_i,
    input  wire rv_pipe_pkg::word_t    ex_rd2_i,
    input  wire rv_pipe_pkg::word_t    ex_imm_i,
    input  wire rv_isa_pkg::alu_op_e   ex_alu_op_i,
    input  wire logic                  ex_src_imm_i,
    input  wire rv_isa_pkg::reg_addr_t ex_rd_i,
    input  wire logic                  ex_we_i,
    input  wire logic                  ex_load_i,
    input  wire logic                  ex_store_i,
    input  wire rv_pipe_pkg::bypass_e  rd1_bp_i,
    input  wire rv_pipe_pkg::bypass_e  rd2_bp_i,
    input  wire rv_pipe_pkg::word_t    mem_result_i,
    input  wire rv_pipe_pkg::word_t    wb_result_i,
    output rv_pipe_pkg::word_t         mem_result_o,
    output rv_pipe_pkg::word_t         mem_wdata_o,
    output rv_isa_pkg::reg_addr_t      mem_rd_o,
    output logic                       mem_we_o,
    output logic                       mem_load_o,
    output logic                       mem_store_o
);

    rv_pipe_pkg::word_t op_a, rd2_fwd, op_b, result;

    function automatic rv_pipe_pkg::word_t fwd(input rv_pipe_pkg::bypass_e sel,
                                               input rv_pipe_pkg::word_t reg_val,
                                               input rv_pipe_pkg::word_t mem_val,
                                               input rv_pipe_pkg::word_t wb_val);
        case (sel)
            rv_pipe_pkg::BP_MEM: return mem_val;
            rv_pipe_pkg::BP_WB:  return wb_val;
            default:             return reg_val;
        endcase
    endfunction

    assign op_a    = fwd(rd1_bp_i, ex_rd1_i, mem_result_i, wb_result_i);
    assign rd2_fwd = fwd(rd2_bp_i, ex_rd2_i, mem_result_i, wb_result_i);  // also store data
    assign op_b    = ex_src_imm_i ? ex_imm_i : rd2_fwd;

    always_comb
    begin
        case (ex_alu_op_i)
            rv_isa_pkg::ALU_SUB: result = op_a - op_b;
            rv_isa_pkg::ALU_AND: result = op_a & op_b;
            rv_isa_pkg::ALU_OR:  result = op_a | op_b;
            rv_isa_pkg::ALU_LUI: result = op_b;
            default:             result = op_a + op_b;  // add, addi, address
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            mem_result_o <= '0;
            mem_wdata_o  <= '0;
            mem_rd_o     <= '0;
            mem_we_o     <= 1'b0;
            mem_load_o   <= 1'b0;
            mem_store_o  <= 1'b0;
        end
        else if (!freeze_i)
        begin
            mem_result_o <= result;
            mem_wdata_o  <= rd2_fwd;
            mem_rd_o     <= ex_rd_i;
            mem_we_o     <= ex_we_i;
            mem_load_o   <= ex_load_i;
            mem_store_o  <= ex_store_i;
        end
    end

endmodule

`default_nettype wire

//--- design/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    input  wire rv_isa_pkg::instr_t    instr_i,
    input  wire rv_pipe_pkg::word_t    pc_i,
    input  wire logic                  cmp1_bp_i,
    input  wire logic                  cmp2_bp_i,
    input  wire rv_pipe_pkg::word_t    mem_result_i,
    input  wire rv_isa_pkg::reg_addr_t wb_rd_i,
    input  wire rv_pipe_pkg::word_t    wb_result_i,
    input  wire logic                  wb_we_i,
    input  wire logic                  flush_i,
    input  wire logic                  stall_i,
    input  wire logic                  freeze_i,
    output rv_isa_pkg::reg_addr_t      ra1_o,
    output rv_isa_pkg::reg_addr_t      ra2_o,
    output logic                       branch_o,
    output logic                       branch_taken_o,
    output rv_pipe_pkg::word_t         branch_target_o,
    output rv_pipe_pkg::word_t         ex_rd1_o,
    output rv_pipe_pkg::word_t         ex_rd2_o,
    output rv_pipe_pkg::word_t         ex_imm_o,
    output rv_isa_pkg::alu_op_e        ex_alu_op_o,
    output logic                       ex_src_imm_o,
    output rv_isa_pkg::reg_addr_t      ex_rd_o,
    output rv_isa_pkg::reg_addr_t      ex_ra1_o,
    output rv_isa_pkg::reg_addr_t      ex_ra2_o,
    output logic                       ex_we_o,
    output logic                       ex_load_o,
    output logic                       ex_store_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    rv_isa_pkg::reg_addr_t rd;
    rv_pipe_pkg::word_t    rd1, rd2, cmp1, cmp2, imm;
    rv_isa_pkg::alu_op_e   alu_op;
    logic                  src_imm, we, load, store;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rd     = instr_i[11:7];
    // unused source fields read x0 so they never stall or forward
    assign ra1_o  = (opcode == rv_isa_pkg::OPC_LUI) ? '0 : instr_i[19:15];
    assign ra2_o  = (opcode inside {rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_STORE,
                     rv_isa_pkg::OPC_BRANCH}) ? instr_i[24:20] : '0;

    rv_reg_file rv_reg_file_inst
    (
        .clk(clk), .arst_n_i(arst_n_i),
        .ra1_i(ra1_o), .ra2_i(ra2_o), .rd1_o(rd1), .rd2_o(rd2),
        .wa_i(wb_rd_i), .wd_i(wb_result_i), .we_i(wb_we_i)
    );

    always_comb
    begin
        imm      = {{20{instr_i[31]}}, instr_i[31:20]};    // I type
        alu_op   = rv_isa_pkg::ALU_ADD;
        src_imm  = 1'b1;
        we       = 1'b0;
        load     = 1'b0;
        store    = 1'b0;
        branch_o = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP:
            begin
                src_imm = 1'b0;
                we      = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD: alu_op = instr_i[rv_isa_pkg::F7_SUB_BIT] ?
                                                 rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
                    rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::ALU_AND;
                    rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::ALU_OR;
                    default:            we = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: we = (funct3 == rv_isa_pkg::F3_ADD);   // addi only
            rv_isa_pkg::OPC_LUI:
            begin
                imm    = {instr_i[31:12], 12'b0};
                alu_op = rv_isa_pkg::ALU_LUI;
                we     = 1'b1;
            end
            rv_isa_pkg::OPC_LOAD:
            begin
                we   = 1'b1;
                load = 1'b1;
            end
            rv_isa_pkg::OPC_STORE:
            begin
                imm   = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                store = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH:
            begin
                imm      = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};
                branch_o = 1'b1;
            end
            default: ;
        endcase
    end

    // wb values reach the compare through the register file
    assign cmp1            = cmp1_bp_i ? mem_result_i : rd1;
    assign cmp2            = cmp2_bp_i ? mem_result_i : rd2;
    assign branch_target_o = pc_i + imm;
    assign branch_taken_o  = branch_o && !stall_i &&
                             ((funct3 == rv_isa_pkg::F3_BEQ && cmp1 == cmp2) ||
                              (funct3 == rv_isa_pkg::F3_BNE && cmp1 != cmp2));

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ex_rd1_o     <= '0;
            ex_rd2_o     <= '0;
            ex_imm_o     <= '0;
            ex_alu_op_o  <= rv_isa_pkg::ALU_ADD;
            ex_src_imm_o <= 1'b0;
            ex_rd_o      <= '0;
            ex_ra1_o     <= '0;
            ex_ra2_o     <= '0;
            ex_we_o      <= 1'b0;
            ex_load_o    <= 1'b0;
            ex_store_o   <= 1'b0;
        end
        else if (!freeze_i)
        begin
            ex_rd1_o     <= rd1;
            ex_rd2_o     <= rd2;
            ex_imm_o     <= imm;
            ex_alu_op_o  <= alu_op;
            ex_src_imm_o <= src_imm;
            ex_rd_o      <= rd;
            ex_ra1_o     <= ra1_o;
            ex_ra2_o     <= ra2_o;
            ex_we_o      <= we && !flush_i;     // bubble keeps no flags
            ex_load_o    <= load && !flush_i;
            ex_store_o   <= store && !flush_i;
        end
    end

    // the decode word after a taken branch is a nop
    a_branch_kill: assert property (@(posedge clk) disable iff (!arst_n_i)
        (branch_taken_o && !freeze_i) |=> (instr_i == rv_isa_pkg::INSTR_NOP));

endmodule

`default_nettype wire

//--- design/rv_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file
(
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    input  wire rv_isa_pkg::reg_addr_t ra1_i,
    input  wire rv_isa_pkg::reg_addr_t ra2_i,
    output rv_pipe_pkg::word_t         rd1_o,
    output rv_pipe_pkg::word_t         rd2_o,
    input  wire rv_isa_pkg::reg_addr_t wa_i,
    input  wire rv_pipe_pkg::word_t    wd_i,
    input  wire logic                  we_i
);

    rv_pipe_pkg::word_t regs [1:31];    // x0 has no storage

    function automatic rv_pipe_pkg::word_t read_port(input rv_isa_pkg::reg_addr_t ra);
        if (ra == '0)
            return '0;
        else if (we_i && ra == wa_i)
            return wd_i;                // write-through
        else
            return regs[ra];
    endfunction

    always_ff @(posedge clk)
    begin
        if (we_i && wa_i != '0)
            regs[wa_i] <= wd_i;
    end

    always_comb
    begin
        rd1_o = read_port(ra1_i);
        rd2_o = read_port(ra2_i);
    end

    // an enabled write carries a known address and value
    a_write_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        we_i |-> (!$isunknown(wa_i) && !$isunknown(wd_i)));

endmodule

`default_nettype wire

//--- design/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
#(
    parameter rv_pipe_pkg::word_t RESET_PC = 32'h0000_0000
)(
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire logic               stall_i,
    input  wire logic               freeze_i,
    input  wire logic               branch_taken_i,
    input  wire rv_pipe_pkg::word_t branch_target_i,
    output rv_pipe_pkg::word_t      instr_addr_o,
    input  wire rv_isa_pkg::instr_t instr_rdata_i,
    output rv_isa_pkg::instr_t      instr_o,
    output rv_pipe_pkg::word_t      pc_o
);

    rv_pipe_pkg::word_t pc_q;       // address on the ROM port
    rv_pipe_pkg::word_t pc_d_q;     // address of the word the ROM returns now
    rv_isa_pkg::instr_t hold_q;     // decode word kept over a stall
    logic               use_hold_q;
    logic               kill_q;     // returning word is wrong path
    logic               hold;

    assign hold         = stall_i || freeze_i;
    assign instr_addr_o = pc_q;
    assign pc_o         = pc_d_q;

    always_comb
    begin
        if (use_hold_q)
            instr_o = hold_q;
        else if (kill_q)
            instr_o = rv_isa_pkg::INSTR_NOP;
        else
            instr_o = instr_rdata_i;
    end

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            pc_q       <= RESET_PC;
            pc_d_q     <= RESET_PC;
            hold_q     <= rv_isa_pkg::INSTR_NOP;
            use_hold_q <= 1'b0;
            kill_q     <= 1'b1;     // ROM output is stale in the first cycle
        end
        else if (hold)
        begin
            hold_q     <= instr_o;
            use_hold_q <= 1'b1;
        end
        else
        begin
            pc_q       <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
            pc_d_q     <= pc_q;
            use_hold_q <= 1'b0;
            kill_q     <= branch_taken_i;
        end
    end

endmodule

`default_nettype wire

//--- design/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    typedef logic [31:0] word_t;

    // operand source in execute
    typedef enum logic [1:0]
    {
        BP_NONE,
        BP_MEM,
        BP_WB
    } bypass_e;

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes of the kept instructions
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_ADD = 3'b000;     // add, sub and addi
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam int F7_SUB_BIT = 30;             // instr[30] turns add into sub

    localparam instr_t INSTR_NOP = 32'h0000_0013;   // addi x0, x0, 0

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LUI     // pass operand b
    } alu_op_e;

endpackage

`default_nettype wire
